// ==== source/coherence_settings.svh ====
`ifndef COHERENCE_SETTINGS_SVH
`define COHERENCE_SETTINGS_SVH

// caches sharing the snoop bus.
`define COHERENCE_CORES 2
// direct-mapped lines per cache; the index width follows from this.
`define LINE_COUNT 4
// line address, low bits index the store and the rest is the tag.
`define ADDRESS_WIDTH 8

`endif

// ==== source/coherencePkg.sv ====
package coherencePkg;

	// line states of the MOESIF protocol.
	typedef enum logic [2:0] {
		INVALID   = 3'd0,
		SHARED    = 3'd1,
		EXCLUSIVE = 3'd2,
		OWNED     = 3'd3,
		MODIFIED  = 3'd4,
		FORWARD   = 3'd5
	} stateType;

	// commands seen on the snoop bus.
	typedef enum logic [2:0] {
		BUS_NONE           = 3'd0,
		BUS_READ           = 3'd1,
		BUS_READ_EXCLUSIVE = 3'd2,
		BUS_INVALIDATE     = 3'd3,
		BUS_WRITEBACK      = 3'd4
	} commandType;

endpackage : coherencePkg

// ==== source/coherenceInterfaces.sv ====
`timescale 1ns/100ps
`include "coherence_settings.svh"

interface CPUProtocolInterface;
	import coherencePkg::*;

	stateType stateOut;
	stateType stateIn;
	logic read;
	logic write;
	logic writeBackRequired;
	logic invalidateRequired;
	logic readExclusiveRequired;

	modport controller (
		output stateOut, read, write,
		input stateIn, writeBackRequired, invalidateRequired, readExclusiveRequired
	);
	modport protocol (
		input stateOut, read, write,
		output stateIn, writeBackRequired, invalidateRequired, readExclusiveRequired
	);
endinterface : CPUProtocolInterface

interface SnoopyProtocolInterface;
	import coherencePkg::*;

	stateType stateOut;
	stateType stateIn;
	commandType commandIn;
	// set when this cache has to supply the snooped line.
	logic request;

	modport controller (output stateOut, commandIn, input stateIn, request);
	modport protocol (input stateOut, commandIn, output stateIn, request);
endinterface : SnoopyProtocolInterface

interface MOESIFInterface;
	logic sharedOut;
	logic sharedIn;

	modport controller (input sharedOut, output sharedIn);
	modport protocol (output sharedOut, input sharedIn);
endinterface : MOESIFInterface

interface coherenceBusInterface;
	import coherencePkg::*;

	logic busRequest;
	commandType requestCommand;
	logic [`ADDRESS_WIDTH-1:0] requestAddress;
	logic sharedOut;
	logic supply;
	logic grant;
	commandType snoopCommand;
	logic [`ADDRESS_WIDTH-1:0] snoopAddress;
	logic sharedIn;
	logic intervention;

	modport cache (
		output busRequest, requestCommand, requestAddress, sharedOut, supply,
		input grant, snoopCommand, snoopAddress, sharedIn, intervention
	);
	modport arbiter (
		input busRequest, requestCommand, requestAddress, sharedOut, supply,
		output grant, snoopCommand, snoopAddress, sharedIn, intervention
	);
endinterface : coherenceBusInterface

// ==== source/MOESIF.sv ====
`timescale 1ns/100ps

module MOESIF (
	CPUProtocolInterface.protocol cpuProtocolInterface,
	SnoopyProtocolInterface.protocol snoopyProtocolInterface,
	MOESIFInterface.protocol moesifInterface
);
	import coherencePkg::*;

	stateType cpuLineState;
	stateType snoopLineState;
	commandType snoopCommand;
	logic cpuRead;
	logic cpuWrite;

	assign cpuLineState = cpuProtocolInterface.stateOut;
	assign cpuRead = cpuProtocolInterface.read;
	assign cpuWrite = cpuProtocolInterface.write;
	assign snoopLineState = snoopyProtocolInterface.stateOut;
	assign snoopCommand = snoopyProtocolInterface.commandIn;

	// dirty lines have to reach memory before their slot is reused.
	assign cpuProtocolInterface.writeBackRequired = cpuLineState == MODIFIED ||
		cpuLineState == OWNED;

	// a write to a copy that others may share only has to kill those copies.
	assign cpuProtocolInterface.invalidateRequired = cpuWrite && (cpuLineState == SHARED ||
		cpuLineState == OWNED || cpuLineState == FORWARD);

	assign cpuProtocolInterface.readExclusiveRequired = cpuWrite && cpuLineState == INVALID;

	always_comb begin
		cpuProtocolInterface.stateIn = cpuLineState;
		case (cpuLineState)
			INVALID: begin
				if (cpuRead) begin
					// another valid copy means this cache becomes the forwarder.
					if (moesifInterface.sharedIn) begin
						cpuProtocolInterface.stateIn = FORWARD;
					end else begin
						cpuProtocolInterface.stateIn = EXCLUSIVE;
					end
				end else if (cpuWrite) begin
					cpuProtocolInterface.stateIn = MODIFIED;
				end
			end

			SHARED, EXCLUSIVE, OWNED, FORWARD: begin
				if (!cpuRead && cpuWrite) begin
					cpuProtocolInterface.stateIn = MODIFIED;
				end
			end

			MODIFIED: begin
				cpuProtocolInterface.stateIn = MODIFIED;
			end

			default: begin
				cpuProtocolInterface.stateIn = INVALID;
			end
		endcase
	end

	// only M, E and F holders answer a read with data.
	assign snoopyProtocolInterface.request = snoopLineState == MODIFIED ||
		snoopLineState == EXCLUSIVE || snoopLineState == FORWARD;

	assign moesifInterface.sharedOut = snoopLineState != INVALID;

	always_comb begin
		snoopyProtocolInterface.stateIn = snoopLineState;
		case (snoopCommand)
			BUS_READ: begin
				case (snoopLineState)
					MODIFIED: begin
						// the dirty data stays here, now shared with the reader.
						snoopyProtocolInterface.stateIn = OWNED;
					end

					EXCLUSIVE, FORWARD: begin
						snoopyProtocolInterface.stateIn = SHARED;
					end

					default: begin
						snoopyProtocolInterface.stateIn = snoopLineState;
					end
				endcase
			end

			BUS_READ_EXCLUSIVE, BUS_INVALIDATE: begin
				snoopyProtocolInterface.stateIn = INVALID;
			end

			default: begin
				snoopyProtocolInterface.stateIn = snoopLineState;
			end
		endcase
	end
endmodule : MOESIF

// ==== source/cacheController.sv ====
`timescale 1ns/100ps
`include "coherence_settings.svh"

module cacheController (
	input logic clk,
	input logic rstN,
	input logic cpuRead,
	input logic cpuWrite,
	input logic [`ADDRESS_WIDTH-1:0] cpuAddress,
	output logic cpuDone,
	output coherencePkg::stateType cpuState,
	coherenceBusInterface.cache bus
);
	import coherencePkg::*;

	localparam int indexWidth = $clog2(`LINE_COUNT);
	localparam int tagWidth = `ADDRESS_WIDTH - indexWidth;

	typedef enum logic [2:0] {IDLE, LOOKUP, WRITEBACK, BUS_CYCLE, DONE} phaseType;

	phaseType phase;
	logic reqRead;
	logic reqWrite;
	logic [`ADDRESS_WIDTH-1:0] reqAddress;
	stateType lineState [`LINE_COUNT];
	logic [tagWidth-1:0] lineTag [`LINE_COUNT];

	logic [indexWidth-1:0] index;
	logic [tagWidth-1:0] reqTag;
	logic tagHit;
	stateType currentState;
	logic needBus;
	commandType fillCommand;
	logic [indexWidth-1:0] snoopIndex;
	logic snoopTagHit;
	logic snoopUpdate;
	logic snoopClash;
	logic hitUpdate;
	logic fillUpdate;
	logic victimDrop;

	CPUProtocolInterface cpuLink ();
	SnoopyProtocolInterface snoopLink ();
	MOESIFInterface moesifLink ();

	MOESIF moesif (
		.cpuProtocolInterface(cpuLink),
		.snoopyProtocolInterface(snoopLink),
		.moesifInterface(moesifLink)
	);

	assign index = reqAddress[indexWidth-1:0];
	assign reqTag = reqAddress[`ADDRESS_WIDTH-1:indexWidth];
	assign tagHit = lineState[index] != INVALID && lineTag[index] == reqTag;
	assign currentState = tagHit ? lineState[index] : INVALID;
	assign cpuState = currentState;
	assign cpuDone = phase == DONE;

	// during lookup the stored line is shown even on a miss, so a dirty victim is seen.
	assign cpuLink.stateOut = phase == LOOKUP ? lineState[index] : currentState;
	assign cpuLink.read = reqRead;
	assign cpuLink.write = reqWrite;
	// a supplier always holds a copy too.
	assign moesifLink.sharedIn = bus.sharedIn | bus.intervention;

	assign needBus = !tagHit || cpuLink.readExclusiveRequired || cpuLink.invalidateRequired;

	always_comb begin
		if (cpuLink.readExclusiveRequired) begin
			fillCommand = BUS_READ_EXCLUSIVE;
		end else if (cpuLink.invalidateRequired) begin
			fillCommand = BUS_INVALIDATE;
		end else begin
			fillCommand = BUS_READ;
		end
	end

	assign bus.busRequest = phase == WRITEBACK || phase == BUS_CYCLE;
	assign bus.requestCommand = phase == WRITEBACK ? BUS_WRITEBACK :
		phase == BUS_CYCLE ? fillCommand : BUS_NONE;
	assign bus.requestAddress = phase == WRITEBACK ? {lineTag[index], index} : reqAddress;

	assign snoopIndex = bus.snoopAddress[indexWidth-1:0];
	assign snoopTagHit = lineState[snoopIndex] != INVALID &&
		lineTag[snoopIndex] == bus.snoopAddress[`ADDRESS_WIDTH-1:indexWidth];
	assign snoopLink.stateOut = snoopTagHit ? lineState[snoopIndex] : INVALID;
	assign snoopLink.commandIn = bus.snoopCommand;
	assign snoopUpdate = snoopTagHit && bus.snoopCommand != BUS_NONE &&
		bus.snoopCommand != BUS_WRITEBACK;
	assign bus.sharedOut = moesifLink.sharedOut;
	assign bus.supply = snoopLink.request;

	// lookup waits a cycle when a snoop rewrites the same line.
	assign snoopClash = snoopUpdate && snoopIndex == index;
	assign hitUpdate = phase == LOOKUP && !snoopClash && !needBus;
	assign fillUpdate = phase == BUS_CYCLE && bus.grant;
	assign victimDrop = phase == WRITEBACK && bus.grant;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			phase <= IDLE;
			reqRead <= 1'b0;
			reqWrite <= 1'b0;
		end else begin
			case (phase)
				IDLE: begin
					if (cpuRead || cpuWrite) begin
						reqRead <= cpuRead;
						reqWrite <= cpuWrite && !cpuRead;
						phase <= LOOKUP;
					end
				end
				LOOKUP: begin
					if (!snoopClash) begin
						if (!tagHit && cpuLink.writeBackRequired) begin
							phase <= WRITEBACK;
						end else if (needBus) begin
							phase <= BUS_CYCLE;
						end else begin
							phase <= DONE;
						end
					end
				end
				WRITEBACK: begin
					if (bus.grant) begin
						phase <= BUS_CYCLE;
					end
				end
				BUS_CYCLE: begin
					if (bus.grant) begin
						phase <= DONE;
					end
				end
				default: begin
					phase <= IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (phase == IDLE) begin
			reqAddress <= cpuAddress;
		end
		if (fillUpdate) begin
			lineTag[index] <= reqTag;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < `LINE_COUNT; i++) begin
				lineState[i] <= INVALID;
			end
		end else begin
			if (victimDrop) begin
				lineState[index] <= INVALID;
			end
			if (hitUpdate || fillUpdate) begin
				lineState[index] <= cpuLink.stateIn;
			end
			if (snoopUpdate) begin
				lineState[snoopIndex] <= snoopLink.stateIn;
			end
		end
	end
endmodule : cacheController

// ==== source/busArbiter.sv ====
`timescale 1ns/100ps
`include "coherence_settings.svh"

module busArbiter (
	input logic clk,
	input logic rstN,
	coherenceBusInterface.arbiter bus [`COHERENCE_CORES],
	output coherencePkg::commandType busCommand,
	output logic [`ADDRESS_WIDTH-1:0] busAddress,
	output logic busIntervention
);
	import coherencePkg::*;

	localparam int coreBits = $clog2(`COHERENCE_CORES);

	logic [`COHERENCE_CORES-1:0] requestVector;
	logic [`COHERENCE_CORES-1:0] sharedVector;
	logic [`COHERENCE_CORES-1:0] supplyVector;
	logic [`COHERENCE_CORES-1:0] grantVector;
	logic [`COHERENCE_CORES-1:0] interventionVector;
	commandType requestCommand [`COHERENCE_CORES];
	logic [`ADDRESS_WIDTH-1:0] requestAddress [`COHERENCE_CORES];
	logic [coreBits-1:0] lastGrant;
	logic [coreBits-1:0] grantIndex;
	logic granted;
	logic dataRead;

	// search starts at the core after the last one granted.
	always_comb begin
		logic [coreBits-1:0] candidate;
		granted = 1'b0;
		grantIndex = '0;
		candidate = lastGrant;
		for (int step = 0; step < `COHERENCE_CORES; step++) begin
			if (candidate == coreBits'(`COHERENCE_CORES - 1)) begin
				candidate = '0;
			end else begin
				candidate = candidate + 1'b1;
			end
			if (!granted && requestVector[candidate]) begin
				granted = 1'b1;
				grantIndex = candidate;
			end
		end
	end

	assign busCommand = granted ? requestCommand[grantIndex] : BUS_NONE;
	assign busAddress = granted ? requestAddress[grantIndex] : '0;
	// data is only supplied for reads.
	assign dataRead = busCommand == BUS_READ || busCommand == BUS_READ_EXCLUSIVE;
	assign busIntervention = |(interventionVector & grantVector);

	for (genvar i = 0; i < `COHERENCE_CORES; i++) begin : port
		localparam logic [`COHERENCE_CORES-1:0] selfMask = `COHERENCE_CORES'(1) << i;

		assign requestVector[i] = bus[i].busRequest;
		assign requestCommand[i] = bus[i].requestCommand;
		assign requestAddress[i] = bus[i].requestAddress;
		assign sharedVector[i] = bus[i].sharedOut;
		assign supplyVector[i] = bus[i].supply;
		assign grantVector[i] = granted && grantIndex == coreBits'(i);
		assign interventionVector[i] = dataRead && |(supplyVector & ~selfMask);

		assign bus[i].grant = grantVector[i];
		assign bus[i].snoopCommand = granted && !grantVector[i] ? busCommand : BUS_NONE;
		assign bus[i].snoopAddress = busAddress;
		assign bus[i].sharedIn = |(sharedVector & ~selfMask);
		assign bus[i].intervention = interventionVector[i];
	end

	// starting from the last core gives core 0 the first grant.
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			lastGrant <= coreBits'(`COHERENCE_CORES - 1);
		end else if (granted) begin
			lastGrant <= grantIndex;
		end
	end
endmodule : busArbiter

// ==== source/coherenceTop.sv ====
`timescale 1ns/100ps
`include "coherence_settings.svh"

module coherenceTop (
	input logic clk,
	input logic rstN,
	input logic [`COHERENCE_CORES-1:0] cpuRead,
	input logic [`COHERENCE_CORES-1:0] cpuWrite,
	input logic [`ADDRESS_WIDTH-1:0] cpuAddress [`COHERENCE_CORES],
	output logic [`COHERENCE_CORES-1:0] cpuDone,
	output coherencePkg::stateType cpuState [`COHERENCE_CORES],
	output coherencePkg::commandType busCommand,
	output logic [`ADDRESS_WIDTH-1:0] busAddress,
	output logic busIntervention
);
	// one bus link per core, all meeting at the arbiter.
	coherenceBusInterface busLink [`COHERENCE_CORES] ();

	for (genvar core = 0; core < `COHERENCE_CORES; core++) begin : cache
		cacheController controller (
			.clk(clk),
			.rstN(rstN),
			.cpuRead(cpuRead[core]),
			.cpuWrite(cpuWrite[core]),
			.cpuAddress(cpuAddress[core]),
			.cpuDone(cpuDone[core]),
			.cpuState(cpuState[core]),
			.bus(busLink[core])
		);
	end

	busArbiter arbiter (
		.clk(clk),
		.rstN(rstN),
		.bus(busLink),
		.busCommand(busCommand),
		.busAddress(busAddress),
		.busIntervention(busIntervention)
	);
endmodule : coherenceTop

// ==== dv/clockGen.sv ====
`timescale 1ns/100ps

module clockGen (
	output logic clk,
	output logic rstN
);
	// 100 ns period.
	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// reset stays low for the first four rising edges.
	initial begin
		rstN = 1'b0;
		repeat (4) @(posedge clk);
		#5;
		rstN = 1'b1;
	end
endmodule : clockGen

// ==== dv/coherence_assertions.sv ====
`timescale 1ns/100ps

module coherenceAssertions (
	input logic clk,
	input logic rstN,
	input logic cpuDone,
	input logic busRequest,
	input logic grant,
	input coherencePkg::commandType snoopCommand
);
	import coherencePkg::*;

	// a request waits with the level held until the arbiter grants it.
	requestHeld: assert property (@(posedge clk) disable iff (!rstN)
		busRequest && !grant |=> busRequest)
		else $error("busRequest dropped before its grant");

	doneSingle: assert property (@(posedge clk) disable iff (!rstN)
		cpuDone |=> !cpuDone)
		else $error("cpuDone stayed high for more than one cycle");

	// while this cache holds the bus, no other cache's command reaches it.
	grantAlone: assert property (@(posedge clk) disable iff (!rstN)
		grant |-> busRequest && snoopCommand == BUS_NONE)
		else $error("grant seen while another command is on the bus");
endmodule : coherenceAssertions

bind cacheController coherenceAssertions protocolChecks (
	.clk(clk),
	.rstN(rstN),
	.cpuDone(cpuDone),
	.busRequest(bus.busRequest),
	.grant(bus.grant),
	.snoopCommand(bus.snoopCommand)
);

// ==== dv/coherenceTb.sv ====
`timescale 1ns/100ps
`include "coherence_settings.svh"

module coherenceTb;
	import coherencePkg::*;

	localparam int coreBits = $clog2(`COHERENCE_CORES);
	localparam int driveDelay = 5;

	typedef logic [coreBits-1:0] coreIndex;
	typedef struct {
		coreIndex core;
		logic [1:0] op;
		logic [`ADDRESS_WIDTH-1:0] address;
		stateType state;
		logic intervention;
		commandType command;
		logic writeBack;
		logic [`ADDRESS_WIDTH-1:0] victim;
		coreIndex core2;
		logic [1:0] op2;
		logic [`ADDRESS_WIDTH-1:0] address2;
		stateType state2;
	} stimLine;

	logic clk;
	logic rstN;
	logic [`COHERENCE_CORES-1:0] cpuRead;
	logic [`COHERENCE_CORES-1:0] cpuWrite;
	logic [`ADDRESS_WIDTH-1:0] cpuAddress [`COHERENCE_CORES];
	logic [`COHERENCE_CORES-1:0] cpuDone;
	stateType cpuState [`COHERENCE_CORES];
	commandType busCommand;
	logic [`ADDRESS_WIDTH-1:0] busAddress;
	logic busIntervention;

	stimLine rows [$];
	logic [31:0] lfsr;
	int cycleCount = 0;
	int cycleLimit = 0;
	int checkCount = 0;
	int stateErrors = 0;
	int commandErrors = 0;
	int flagErrors = 0;
	int addressErrors = 0;
	int otherErrors = 0;

	clockGen clockSource (.clk(clk), .rstN(rstN));

	coherenceTop UUT (
		.clk(clk),
		.rstN(rstN),
		.cpuRead(cpuRead),
		.cpuWrite(cpuWrite),
		.cpuAddress(cpuAddress),
		.cpuDone(cpuDone),
		.cpuState(cpuState),
		.busCommand(busCommand),
		.busAddress(busAddress),
		.busIntervention(busIntervention)
	);

	// galois form of x^32 + x^22 + x^2 + x + 1, shifting right.
	function automatic logic [31:0] stepLfsr(input logic [31:0] state);
		return state[0] ? (state >> 1) ^ 32'h80200003 : state >> 1;
	endfunction

	task automatic checkState(input string name, input stateType actual,
		input stateType expected);
		checkCount++;
		if (actual !== expected) begin
			stateErrors++;
			$display("CHECK FAILED at %0t: %s is %s, expected %s", $time, name,
				actual.name(), expected.name());
		end
	endtask

	task automatic checkCommand(input string name, input commandType actual,
		input commandType expected);
		checkCount++;
		if (actual !== expected) begin
			commandErrors++;
			$display("CHECK FAILED at %0t: %s is %s, expected %s", $time, name,
				actual.name(), expected.name());
		end
	endtask

	task automatic checkFlag(input string name, input logic actual, input logic expected);
		checkCount++;
		if (actual !== expected) begin
			flagErrors++;
			$display("CHECK FAILED at %0t: %s is %b, expected %b", $time, name, actual, expected);
		end
	endtask

	task automatic checkAddress(input string name, input logic [`ADDRESS_WIDTH-1:0] actual,
		input logic [`ADDRESS_WIDTH-1:0] expected);
		checkCount++;
		if (actual !== expected) begin
			addressErrors++;
			$display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, actual, expected);
		end
	endtask

	task automatic printSummary();
		$display("%0d checks, errors: %0d state, %0d command, %0d flag, %0d address, %0d other",
			checkCount, stateErrors, commandErrors, flagErrors, addressErrors, otherErrors);
	endtask

	// two LFSR bits give a pause of 0 to 3 cycles.
	task automatic idleGap();
		int gap;
		gap = 0;
		for (int b = 0; b < 2; b++) begin
			gap = gap * 2 + int'(lfsr[0]);
			lfsr = stepLfsr(lfsr);
		end
		repeat (gap) @(posedge clk);
	endtask

	task automatic startRequest(input coreIndex core, input logic [1:0] op,
		input logic [`ADDRESS_WIDTH-1:0] address, inout logic [`COHERENCE_CORES-1:0] pending);
		cpuAddress[core] = address;
		cpuRead[core] = op == 2'd1;
		cpuWrite[core] = op == 2'd2;
		pending[core] = 1'b1;
	endtask

	task automatic runLine(input stimLine row);
		logic [`COHERENCE_CORES-1:0] pending;
		logic [`COHERENCE_CORES-1:0] finished;
		commandType lastCommand;
		logic lastIntervention;
		logic writeBackSeen;
		logic [`ADDRESS_WIDTH-1:0] writeBackAddress;
		pending = '0;
		lastCommand = BUS_NONE;
		lastIntervention = 1'b0;
		writeBackSeen = 1'b0;
		writeBackAddress = '0;
		@(posedge clk);
		#driveDelay;
		startRequest(row.core, row.op, row.address, pending);
		if (row.op2 != 2'd0) begin
			startRequest(row.core2, row.op2, row.address2, pending);
		end
		while (pending != '0) begin
			@(negedge clk);
			finished = pending & cpuDone;
			// the cycle before cpuDone is the requester's own granted bus cycle.
			if (finished[row.core]) begin
				checkState($sformatf("cpuState[%0d]", row.core), cpuState[row.core], row.state);
				checkCommand("busCommand", lastCommand, row.command);
				checkFlag("busIntervention", lastIntervention, row.intervention);
			end
			if (row.op2 != 2'd0 && finished[row.core2]) begin
				checkState($sformatf("cpuState[%0d]", row.core2), cpuState[row.core2], row.state2);
			end
			if (busCommand == BUS_WRITEBACK) begin
				writeBackSeen = 1'b1;
				writeBackAddress = busAddress;
			end
			lastCommand = busCommand;
			lastIntervention = busIntervention;
			pending = pending & ~finished;
			@(posedge clk);
			#driveDelay;
			cpuRead = cpuRead & ~finished;
			cpuWrite = cpuWrite & ~finished;
		end
		checkFlag("writeback on busCommand", writeBackSeen, row.writeBack);
		if (row.writeBack) begin
			checkAddress("busAddress", writeBackAddress, row.victim);
		end
	endtask

	always @(posedge clk) begin
		cycleCount++;
		if (cycleLimit > 0 && cycleCount > cycleLimit) begin
			otherErrors++;
			$display("timeout: the tests did not finish within %0d cycles", cycleLimit);
			printSummary();
			$display("Simulation FAILED");
			$finish;
		end
	end

	initial begin
		int fileHandle;
		int count;
		int field [12];
		string text;
		stimLine row;
		cpuRead = '0;
		cpuWrite = '0;
		cpuAddress = '{default: '0};
		lfsr = 32'h85b24495;
		fileHandle = $fopen("dv/coherence_stim.txt", "r");
		if (fileHandle == 0) begin
			otherErrors++;
			$display("the stimulus file dv/coherence_stim.txt could not be opened");
		end else begin
			while ($fgets(text, fileHandle) != 0) begin
				count = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h", field[0],
					field[1], field[2], field[3], field[4], field[5], field[6], field[7],
					field[8], field[9], field[10], field[11]);
				if (count == 12) begin
					row.core = field[0][coreBits-1:0];
					row.op = field[1][1:0];
					row.address = field[2][`ADDRESS_WIDTH-1:0];
					row.state = stateType'(field[3][2:0]);
					row.intervention = field[4][0];
					row.command = commandType'(field[5][2:0]);
					row.writeBack = field[6][0];
					row.victim = field[7][`ADDRESS_WIDTH-1:0];
					row.core2 = field[8][coreBits-1:0];
					row.op2 = field[9][1:0];
					row.address2 = field[10][`ADDRESS_WIDTH-1:0];
					row.state2 = stateType'(field[11][2:0]);
					rows.push_back(row);
				end else if (count > 0) begin
					otherErrors++;
					$display("a stimulus line has %0d fields instead of 12: %s", count, text);
				end
			end
			$fclose(fileHandle);
		end
		if (rows.size() == 0) begin
			otherErrors++;
			$display("no stimulus lines were read");
		end
		cycleLimit = rows.size() * 40 + 8;
		wait (rstN === 1'b1);
		foreach (rows[i]) begin
			idleGap();
			runLine(rows[i]);
		end
		repeat (2) @(posedge clk);
		printSummary();
		if (stateErrors + commandErrors + flagErrors + addressErrors + otherErrors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end
endmodule : coherenceTb

// ==== dv/coherence_stim.txt ====
# core op address state intervention command writeback victim core2 op2 address2 state2
# hex; op 0 none 1 read 2 write; state I0 S1 E2 O3 M4 F5; command NONE0 READ1 RDX2 INV3 WB4
# read miss alone, then a second reader gets the line forwarded.
0 1 10 2 0 1 0 00 1 0 00 0
1 1 10 5 1 1 0 00 0 0 00 0
0 1 10 1 0 0 0 00 1 0 00 0
# write in shared, reread from the modified holder, write in owned.
0 2 10 4 0 3 0 00 1 0 00 0
1 1 10 5 1 1 0 00 0 0 00 0
0 2 10 4 0 3 0 00 1 0 00 0
0 2 10 4 0 0 0 00 1 0 00 0
# exclusive write hit, then a write miss takes the line away.
1 1 21 2 0 1 0 00 0 0 00 0
1 2 21 4 0 0 0 00 0 0 00 0
0 2 21 4 1 2 0 00 1 0 00 0
# modified victim written back, then the invalidated core reads alone.
0 1 25 2 0 1 1 21 1 0 00 0
1 1 21 2 0 1 0 00 0 0 00 0
1 1 25 5 1 1 0 00 0 0 00 0
# owned victim.
0 2 32 4 0 2 0 00 1 0 00 0
1 1 32 5 1 1 0 00 0 0 00 0
0 1 36 2 0 1 1 32 1 0 00 0
0 2 36 4 0 0 0 00 1 0 00 0
# both cores at once.
0 2 13 4 0 2 0 00 1 2 2b 4
1 2 32 4 0 3 0 00 0 1 25 1
# modified read hit, share it, then evict the owned copy.
0 1 10 4 0 0 0 00 1 0 00 0
1 1 10 5 1 1 0 00 0 0 00 0
0 1 14 2 0 1 1 10 1 0 00 0

// ==== list.f ====
+incdir+source
source/coherencePkg.sv
source/coherenceInterfaces.sv
source/MOESIF.sv
source/cacheController.sv
source/busArbiter.sv
source/coherenceTop.sv
dv/clockGen.sv
dv/coherence_assertions.sv
dv/coherenceTb.sv

// ==== run.sh ====
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module coherenceTb -o coherenceSim
if [ $? -ne 0 ]; then
	echo "run.sh: Verilator build failed"
	exit 1
fi

./obj_dir/coherenceSim > sim.log 2>&1
runStatus=$?
cat sim.log
if [ $runStatus -ne 0 ]; then
	echo "run.sh: simulation exited with status $runStatus"
	exit 1
fi

if grep -q "^Simulation PASSED$" sim.log; then
	exit 0
fi
echo "run.sh: pass message not found in sim.log"
exit 1
